// ==== src.f ====
+incdir+hdl
hdl/mio_pkg.sv
hdl/mio_if.sv
hdl/mio_decode.sv
hdl/data_ram.sv
hdl/gpio_port.sv
hdl/timer_bank.sv
hdl/mio_top.sv
sim/tb_mio_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_mio_top -f src.f --Mdir obj_dir -o tb_mio_top

# A failing check ends in $fatal, which gives a nonzero exit status
./obj_dir/tb_mio_top

// ==== sim/tb_mio_top.sv ====
`timescale 1ns/1ps
`include "mio_config.svh"

module tb_mio_top import mio_pkg::*; ();

    localparam int clk_period  = 40;
    // Worst case cycles of the first reset and of each test in order
    localparam int test_cycles = 16 + 96 + 8 + 204 + 48 + 86 + 167;

    logic        clk;
    logic        rst;
    logic        mem_w;
    logic        mem_rd;
    logic [31:0] addr;
    logic [31:0] data_wr;
    logic [15:0] switch;
    logic [31:0] data_rd;
    logic        rdata_valid;
    logic [31:0] disp_num;
    logic        led_clk;
    logic        led_do;
    logic        led_pen;
    logic [2:0]  tmr_out;

    logic [31:0] lfsr_state = 32'ha2e6_0fe6;
    logic [31:0] ram_model [int];

    mio_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(clk_period * (test_cycles + 100));
        stop_run("Watchdog expired before the tests finished");
    end

    ////////////////////////////////////////////////////////////
    // Random bits and result checks
    ////////////////////////////////////////////////////////////

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            stop_run($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic check_led(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
        if (act !== exp) begin
            stop_run($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic check_tmr_out(input string name, input logic [2:0] exp,
                                 input logic [2:0] act);
        if (act !== exp) begin
            stop_run($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus access, all called on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic apply_reset();
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        mem_w   = 1'b1;
        addr    = a;
        data_wr = d;
        @(negedge clk);
        mem_w = 1'b0;
    endtask

    // Data lands one cycle after the edge that samples mem_rd
    task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
        mem_rd = 1'b1;
        addr   = a;
        @(negedge clk);
        mem_rd = 1'b0;
        @(negedge clk);
        if (rdata_valid !== 1'b1) begin
            stop_run($sformatf("rdata_valid missing one cycle after the read of 0x%h", a));
        end
        d = data_rd;
    endtask

    task automatic select_channel(input logic [1:0] cs);
        bus_write(`MIO_GPIO_ADDR, {14'h0000, cs, 16'h0000});
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic ram_readback();
        logic [9:0]  idx;
        logic [31:0] d;
        logic [31:0] got;
        for (int i = 0; i < 32; i++) begin
            idx = 10'(rand_bits(10));
            d   = rand_bits(32);
            ram_model[int'(idx)] = d;
            bus_write({20'h00000, idx, 2'b00}, d);
        end
        foreach (ram_model[k]) begin
            bus_read({20'h00000, 10'(k), 2'b00}, got);
            check_word("data_rd (RAM)", ram_model[k], got);
        end
    endtask

    task automatic map_and_readback();
        logic [31:0] d;
        logic [31:0] got;
        int          k;
        d = rand_bits(32);
        bus_write(`MIO_DISP_ADDR, d);
        check_word("disp_num", d, disp_num);
        switch = 16'(rand_bits(16));
        bus_read(`MIO_DISP_ADDR, got);
        check_word("data_rd (switch)", {16'h0000, switch}, got);
        // Unmapped store whose low bits alias a written RAM word
        void'(ram_model.first(k));
        bus_write(32'h8000_0000 | {20'h00000, 10'(k), 2'b00}, ~ram_model[k]);
        check_word("disp_num", d, disp_num);
        bus_read(32'h8000_0000, got);
        check_word("data_rd (unmapped)", 32'h0000_0000, got);
        bus_read({20'h00000, 10'(k), 2'b00}, got);
        check_word("data_rd (RAM)", ram_model[k], got);
    endtask

    task automatic led_shift();
        logic [15:0] word;
        logic [1:0]  cs;
        logic [15:0] bits;
        logic [31:0] got;
        logic        clk_prev;
        int          n;
        int          waited;
        word = 16'(rand_bits(16));
        cs   = 2'(rand_bits(2));
        bits = '0;
        n    = 0;
        waited = 0;
        bus_write(`MIO_GPIO_ADDR, {14'h0000, cs, word});
        clk_prev = led_clk;
        while (led_pen !== 1'b1) begin
            if (waited > 200) begin
                stop_run("led_pen never pulsed after the GPIO write");
            end
            @(negedge clk);
            waited++;
            // Capture on each rising led_clk
            if (led_clk && !clk_prev) begin
                bits = {bits[14:0], led_do};
                n++;
            end
            clk_prev = led_clk;
        end
        if (n != 16) begin
            stop_run($sformatf("Saw %0d led_clk rising edges in a frame instead of 16", n));
        end
        check_led("led_do", word, bits);
        bus_read(`MIO_GPIO_ADDR, got);
        check_led("led_state", word, got[15:0]);
        check_word("data_rd (GPIO)", {3'b000, 11'h000, cs, word}, got);
    endtask

    task automatic timer_one_shot();
        tmr_word_u   cw;
        logic [31:0] n_load;
        logic [31:0] cnt;
        logic [31:0] prev;
        int          polls;
        cw = '0;
        cw.ctrl.ch[1].enable = 1'b1;
        select_channel(2'd3);
        bus_write(`MIO_TMR_ADDR, cw.value);
        select_channel(2'd1);
        n_load = 32'd8 + rand_bits(4);
        bus_write(`MIO_TMR_ADDR, n_load);
        prev  = n_load;
        polls = 0;
        while (tmr_out[1] !== 1'b1) begin
            if (polls > 20) begin
                stop_run("Timer 1 never raised tmr_out in one-shot mode");
            end
            bus_read(`MIO_TMR_ADDR, cnt);
            polls++;
            if (cnt > prev) begin
                stop_run("Timer 1 count went up while counting down");
            end
            if (tmr_out[1] !== 1'b1 && cnt == 32'd0) begin
                stop_run("Timer 1 read zero while its tmr_out was still low");
            end
            prev = cnt;
        end
        bus_read(`MIO_TMR_ADDR, cnt);
        check_word("data_rd (timer 1)", 32'h0000_0000, cnt);
        check_tmr_out("tmr_out", 3'b010, tmr_out);
    endtask

    task automatic timer_periodic();
        tmr_word_u   cw;
        logic [31:0] n_load;
        logic [31:0] cnt;
        logic [31:0] prev;
        logic        level;
        int          toggles;
        int          polls;
        cw = '0;
        cw.ctrl.ch[0].enable   = 1'b1;
        cw.ctrl.ch[0].periodic = 1'b1;
        select_channel(2'd3);
        bus_write(`MIO_TMR_ADDR, cw.value);
        select_channel(2'd0);
        n_load = 32'd6 + rand_bits(3);
        bus_write(`MIO_TMR_ADDR, n_load);
        // Channel 1 holds its one-shot flag
        check_tmr_out("tmr_out", 3'b010, tmr_out);
        level   = 1'b0;
        prev    = n_load;
        toggles = 0;
        polls   = 0;
        while (toggles < 2) begin
            if (polls > 40) begin
                stop_run("Timer 0 did not toggle tmr_out twice in periodic mode");
            end
            bus_read(`MIO_TMR_ADDR, cnt);
            polls++;
            if (cnt == 32'd0 || cnt > n_load) begin
                stop_run($sformatf("Timer 0 count 0x%h is outside 1 to 0x%h", cnt, n_load));
            end
            // Reads are two cycles apart, so a reload shows as N or N-1
            if (cnt > prev && cnt < n_load - 32'd1) begin
                stop_run("Timer 0 did not reload to its written value");
            end
            if (tmr_out[0] !== level) begin
                level = tmr_out[0];
                toggles++;
            end
            prev = cnt;
        end
    endtask

    task automatic reset_midway();
        logic [31:0] got;
        int          waited;
        bus_write(`MIO_DISP_ADDR, rand_bits(32));
        // Channel 2 stays disabled and holds its count
        select_channel(2'd2);
        bus_write(`MIO_TMR_ADDR, 32'd1 + rand_bits(8));
        bus_write(`MIO_GPIO_ADDR, {14'h0000, 2'd0, 16'hFFFF});
        // Stream reads so one is in flight when reset hits
        mem_rd = 1'b1;
        addr   = `MIO_TMR_ADDR;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 140) begin
                stop_run("The all-ones LED frame never started before the reset");
            end
        end while (!(led_do === 1'b1 && led_clk === 1'b1));
        // Reset lands while led_clk is high in the middle of a bit
        mem_rd = 1'b0;
        rst    = 1'b1;
        @(negedge clk);
        check_bit("rdata_valid", 1'b0, rdata_valid);
        apply_reset();
        check_bit("led_clk", 1'b0, led_clk);
        check_bit("led_do", 1'b0, led_do);
        check_bit("led_pen", 1'b0, led_pen);
        check_tmr_out("tmr_out", 3'b000, tmr_out);
        check_word("disp_num", 32'h0000_0000, disp_num);
        bus_read(`MIO_TMR_ADDR, got);
        check_word("data_rd (timer 0)", 32'h0000_0000, got);
        select_channel(2'd2);
        bus_read(`MIO_TMR_ADDR, got);
        check_word("data_rd (timer 2)", 32'h0000_0000, got);
    endtask

    initial begin
        rst     = 1'b1;
        mem_w   = 1'b0;
        mem_rd  = 1'b0;
        addr    = '0;
        data_wr = '0;
        switch  = '0;
        apply_reset();
        ram_readback();
        map_and_readback();
        led_shift();
        timer_one_shot();
        timer_periodic();
        reset_midway();
        $display("Test OK");
        $finish;
    end

endmodule

// ==== hdl/mio_top.sv ====
`timescale 1ns/1ps

module mio_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_w,
    input  logic        mem_rd,
    input  logic [31:0] addr,
    input  logic [31:0] data_wr,
    input  logic [15:0] switch,
    output logic [31:0] data_rd,
    output logic        rdata_valid,
    output logic [31:0] disp_num,
    output logic        led_clk,
    output logic        led_do,
    output logic        led_pen,
    output logic [2:0]  tmr_out
);

    mio_if bus ();

    ////////////////////////////////////////////////////////////
    // Decoder
    ////////////////////////////////////////////////////////////

    mio_decode decode (
        .clk         (clk),
        .rst         (rst),
        .mem_w       (mem_w),
        .mem_rd      (mem_rd),
        .addr        (addr),
        .data_wr     (data_wr),
        .switch      (switch),
        .data_rd     (data_rd),
        .rdata_valid (rdata_valid),
        .bus         (bus.ctrl)
    );

    ////////////////////////////////////////////////////////////
    // Datapaths
    ////////////////////////////////////////////////////////////

    data_ram data_mem (
        .clk (clk),
        .bus (bus.ram)
    );

    gpio_port gpio (
        .clk      (clk),
        .rst      (rst),
        .disp_num (disp_num),
        .led_clk  (led_clk),
        .led_do   (led_do),
        .led_pen  (led_pen),
        .bus      (bus.gpio)
    );

    timer_bank timers (
        .clk (clk),
        .rst (rst),
        .bus (bus.tmr)
    );

    // Timer outputs also go off chip
    assign tmr_out = bus.tmr_out;

endmodule

// ==== hdl/timer_bank.sv ====
`timescale 1ns/1ps

module timer_bank import mio_pkg::*; (
    input  logic clk,
    input  logic rst,
    mio_if.tmr   bus
);

    tmr_word_u   word;
    tmr_word_u   ctrl_q;
    logic [31:0] count  [3];
    logic [31:0] reload [3];
    logic [2:0]  out_q;
    logic [2:0]  pre_cnt;
    logic [2:0]  tick;
    logic [2:0]  load;
    logic        ctrl_we;

    assign word    = bus.wdata;
    // Channel select 3 addresses the control word
    assign ctrl_we = bus.tmr_we && (bus.counter_set == 2'd3);

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            load[i] = bus.tmr_we && (bus.counter_set == 2'(i));
            case (ctrl_q.ctrl.ch[i].prescale)
                2'd0:    tick[i] = 1'b1;
                2'd1:    tick[i] = pre_cnt[0];
                2'd2:    tick[i] = &pre_cnt[1:0];
                default: tick[i] = &pre_cnt;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Control word and prescaler
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q  <= '0;
            pre_cnt <= '0;
        end else begin
            if (ctrl_we) begin
                ctrl_q <= word;
            end
            // Restarts on any value write
            pre_cnt <= (|load) ? 3'd0 : pre_cnt + 3'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Down counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            if (load[i]) begin
                reload[i] <= word.value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                count[i] <= '0;
            end
            out_q <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (load[i]) begin
                    count[i] <= word.value;
                    out_q[i] <= 1'b0;
                end else if (ctrl_q.ctrl.ch[i].enable && tick[i] && (count[i] != 0)) begin
                    if (count[i] == 32'd1) begin
                        if (ctrl_q.ctrl.ch[i].periodic) begin
                            count[i] <= reload[i];
                            out_q[i] <= ~out_q[i];
                        end else begin
                            count[i] <= '0;
                            out_q[i] <= 1'b1;
                        end
                    end else begin
                        count[i] <= count[i] - 32'd1;
                    end
                end
            end
        end
    end

    // Count of the selected channel, none for the control word
    always_comb begin
        case (bus.counter_set)
            2'd0:    bus.tmr_rdata = count[0];
            2'd1:    bus.tmr_rdata = count[1];
            2'd2:    bus.tmr_rdata = count[2];
            default: bus.tmr_rdata = 32'h0000_0000;
        endcase
    end

    assign bus.tmr_out = out_q;

endmodule

// ==== hdl/gpio_port.sv ====
`timescale 1ns/1ps
`include "mio_config.svh"

module gpio_port (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] disp_num,
    output logic        led_clk,
    output logic        led_do,
    output logic        led_pen,
    mio_if.gpio         bus
);

    localparam int DivW = ($clog2(`MIO_LED_DIV) > 0) ? $clog2(`MIO_LED_DIV) : 1;

    logic [17:0]     gpio_q;
    logic [15:0]     shift_q;
    logic [DivW-1:0] div_cnt;
    logic [3:0]      bit_cnt;
    logic            busy;
    logic            pending;
    logic            load;
    logic            half_done;

    ////////////////////////////////////////////////////////////
    // Display and GPIO registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            disp_num <= '0;
            gpio_q   <= '0;
        end else begin
            if (bus.disp_we) begin
                disp_num <= bus.wdata;
            end
            if (bus.gpio_we) begin
                gpio_q <= bus.wdata[17:0];
            end
        end
    end

    assign bus.led_state   = gpio_q[15:0];
    assign bus.counter_set = gpio_q[17:16];

    ////////////////////////////////////////////////////////////
    // Serial LED shifter
    ////////////////////////////////////////////////////////////

    // Start a frame from the latest word once idle
    assign load      = !busy && pending;
    assign half_done = (div_cnt == DivW'(`MIO_LED_DIV - 1));
    // MSB first, data changes while led_clk is low
    assign led_do    = shift_q[15];

    always_ff @(posedge clk) begin
        if (rst) begin
            shift_q <= '0;
            div_cnt <= '0;
            bit_cnt <= '0;
            busy    <= 1'b0;
            pending <= 1'b0;
            led_clk <= 1'b0;
            led_pen <= 1'b0;
        end else begin
            led_pen <= 1'b0;
            pending <= bus.gpio_we || (pending && !load);
            if (load) begin
                shift_q <= bus.led_state;
                div_cnt <= '0;
                bit_cnt <= '0;
                led_clk <= 1'b0;
                busy    <= 1'b1;
            end else if (busy) begin
                if (half_done) begin
                    div_cnt <= '0;
                    led_clk <= ~led_clk;
                    // Falling edge ends the bit
                    if (led_clk) begin
                        shift_q <= {shift_q[14:0], 1'b0};
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd15) begin
                            busy    <= 1'b0;
                            led_pen <= 1'b1;
                        end
                    end
                end else begin
                    div_cnt <= div_cnt + DivW'(1);
                end
            end
        end
    end

endmodule

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ps
`include "mio_config.svh"

module data_ram (
    input  logic clk,
    mio_if.ram   bus
);

    logic [31:0] mem [`MIO_RAM_WORDS];

    ////////////////////////////////////////////////////////////
    // Single port, read every cycle
    ////////////////////////////////////////////////////////////

    // Write and registered read share the port
    always_ff @(posedge clk) begin
        if (bus.ram_we) begin
            mem[bus.ram_addr] <= bus.wdata;
        end
    end

    // Old data on a same-cycle write
    always_ff @(posedge clk) begin
        bus.ram_rdata <= mem[bus.ram_addr];
    end

endmodule

// ==== hdl/mio_decode.sv ====
`timescale 1ns/1ps
`include "mio_config.svh"

module mio_decode import mio_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_w,
    input  logic        mem_rd,
    input  logic [31:0] addr,
    input  logic [31:0] data_wr,
    input  logic [15:0] switch,
    output logic [31:0] data_rd,
    output logic        rdata_valid,
    mio_if.ctrl         bus
);

    mio_region_e region;
    mio_region_e rd_region;
    logic        rd_pending;
    logic [31:0] rd_mux;

    ////////////////////////////////////////////////////////////
    // Address decode and write strobes
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (addr <= `MIO_RAM_TOP) begin
            region = region_ram;
        end else if (addr == `MIO_DISP_ADDR) begin
            region = region_disp;
        end else if (addr == `MIO_GPIO_ADDR) begin
            region = region_gpio;
        end else if (addr == `MIO_TMR_ADDR) begin
            region = region_tmr;
        end else begin
            region = region_none;
        end
    end

    assign bus.wdata    = data_wr;
    // Word address into the RAM
    assign bus.ram_addr = addr[11:2];

    assign bus.ram_we  = mem_w && (region == region_ram);
    assign bus.disp_we = mem_w && (region == region_disp);
    assign bus.gpio_we = mem_w && (region == region_gpio);
    assign bus.tmr_we  = mem_w && (region == region_tmr);

    ////////////////////////////////////////////////////////////
    // Readback
    ////////////////////////////////////////////////////////////

    // Hold the region for one cycle while the RAM output settles
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pending <= 1'b0;
            rd_region  <= region_none;
        end else begin
            rd_pending <= mem_rd;
            rd_region  <= mem_rd ? region : region_none;
        end
    end

    always_comb begin
        case (rd_region)
            region_ram:  rd_mux = bus.ram_rdata;
            region_disp: rd_mux = {16'h0000, switch};
            region_gpio: rd_mux = {bus.tmr_out, 11'h000, bus.counter_set, bus.led_state};
            region_tmr:  rd_mux = bus.tmr_rdata;
            default:     rd_mux = 32'h0000_0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= rd_pending;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pending) begin
            data_rd <= rd_mux;
        end
    end

endmodule

// ==== hdl/mio_if.sv ====
`timescale 1ns/1ps

interface mio_if;

    // Write side, all from the decoder
    logic [31:0] wdata;
    logic [9:0]  ram_addr;
    logic        ram_we;
    logic        disp_we;
    logic        gpio_we;
    logic        tmr_we;

    // Readback and status from the datapaths
    logic [31:0] ram_rdata;
    logic [1:0]  counter_set;
    logic [15:0] led_state;
    logic [31:0] tmr_rdata;
    logic [2:0]  tmr_out;

    modport ctrl (
        output wdata, ram_addr, ram_we, disp_we, gpio_we, tmr_we,
        input  ram_rdata, counter_set, led_state, tmr_rdata, tmr_out
    );

    modport ram (
        input  wdata, ram_addr, ram_we,
        output ram_rdata
    );

    modport gpio (
        input  wdata, disp_we, gpio_we,
        output counter_set, led_state
    );

    // Timer needs counter_set to pick a channel
    modport tmr (
        input  wdata, tmr_we, counter_set,
        output tmr_rdata, tmr_out
    );

endinterface

// ==== hdl/mio_pkg.sv ====
package mio_pkg;

    ////////////////////////////////////////////////////////////
    // Bus decode
    ////////////////////////////////////////////////////////////

    // Target of a load or store
    typedef enum logic [2:0] {
        region_ram,
        region_disp,
        region_gpio,
        region_tmr,
        region_none
    } mio_region_e;

    ////////////////////////////////////////////////////////////
    // Timer words
    ////////////////////////////////////////////////////////////

    // Per-channel control byte
    typedef struct packed {
        logic       enable;
        logic       periodic;   // 0 is one-shot
        logic [1:0] prescale;   // tick every 1, 2, 4 or 8 cycles
        logic [3:0] reserved;
    } tmr_ch_ctrl_t;

    // Timer write word, seen as a count when counter_set is 0..2
    // and as the control word when counter_set is 3.
    // Channel 0 sits in the low byte
    typedef union packed {
        logic [31:0] value;
        struct packed {
            logic [7:0]              reserved;
            tmr_ch_ctrl_t [2:0]      ch;
        } ctrl;
    } tmr_word_u;

endpackage

// ==== hdl/mio_config.svh ====
`ifndef MIO_CONFIG_SVH
`define MIO_CONFIG_SVH

////////////////////////////////////////////////////////////
// Address map
////////////////////////////////////////////////////////////

// RAM covers byte addresses 0 up to MIO_RAM_TOP
`define MIO_RAM_TOP   32'h0000_0FFF
`define MIO_DISP_ADDR 32'hE000_0000
`define MIO_GPIO_ADDR 32'hF000_0000
`define MIO_TMR_ADDR  32'hF000_0004

// Data RAM depth in 32-bit words
`define MIO_RAM_WORDS 1024

// Cycles per half period of led_clk
`define MIO_LED_DIV   2

`endif
